/* include/csumParams.svh */
`ifndef CSUM_PARAMS_SVH
`define CSUM_PARAMS_SVH

// checksum word width in bits
`define CSUM_WIDTH 16

// packet buffer geometry
`define BUF_DEPTH 64
`define BUF_AW 6    // log2 of BUF_DEPTH

// host, engine A, engine B
`define WB_MASTERS 3

`endif

/* src/CsumPkg.sv */
`include "csumParams.svh"

// arithmetic side of the checksum datapath
package CsumPkg;

	// one word as loaded by the host
	typedef logic [`CSUM_WIDTH-1:0] word_t;

	// running sum mod 2^16-1, always 0..65534
	typedef logic [`CSUM_WIDTH-1:0] residue_t;

	// word count, 0 up to a full buffer
	typedef logic [$clog2(`BUF_DEPTH+1)-1:0] len_t;

	// prefix structure of the end-around-carry adder
	typedef enum int {
		serial    = 0,  // ripple-style prefix, smallest
		brentKung = 1,  // 2*log2(n)-1 levels
		sklansky  = 2   // log2(n) levels, high fanout
	} speed_e;

endpackage

/* src/WbPkg.sv */
`include "csumParams.svh"

// wishbone side, shared by bus, arbiter and buffer
package WbPkg;

	typedef logic [`BUF_AW-1:0] adr_t;      // word address into buffer
	typedef logic [`CSUM_WIDTH-1:0] dat_t;  // bus data, one word

	// master index on the arbiter
	typedef logic [1:0] mst_t;

	localparam mst_t mstHost = 2'd0;  // host port
	localparam mst_t mstA    = 2'd1;  // engine A, serial prefix
	localparam mst_t mstB    = 2'd2;  // engine B, sklansky prefix

endpackage

/* src/WbBus.sv */
`timescale 1ns/100ps

// wishbone classic, single word transfers only
interface WbBus;

	logic        cyc;   // bus cycle in progress
	logic        stb;   // valid transfer
	logic        we;    // 1 = write
	WbPkg::adr_t adr;
	WbPkg::dat_t datW;  // master to slave
	WbPkg::dat_t datR;  // slave to master, valid with ack
	logic        ack;

	modport master (
		output cyc, stb, we, adr, datW,
		input  datR, ack
	);

	modport slave (
		input  cyc, stb, we, adr, datW,
		output datR, ack
	);

endinterface

/* src/AddMod2Nm1s0.sv */
`timescale 1ns/100ps

// S = A + B mod (2^width - 1), single zero
module AddMod2Nm1s0 #(
	parameter int width = 16,  // word width
	parameter int speed = 0    // prefix structure, a CsumPkg::speed_e value
) (
	input  logic [width-1:0] A,
	input  logic [width-1:0] B,
	output logic [width-1:0] S
);

	logic [width-1:0] gIn, pIn;    // bitwise generate / propagate
	logic [width-1:0] gOut, pOut;  // prefix results incl. carry-in level
	logic [width-1:0] halfSum;     // A xor B
	logic cIn, cOut;               // end-around carry

	assign gIn     = A & B;
	assign pIn     = A | B;
	assign halfSum = gIn ^ pIn;  // same as A ^ B

	PrefixAndOrCendaround #(
		.width(width),
		.speed(speed)
	) i_prefix (
		.GI(gIn),
		.PI(pIn),
		.CI(cIn),
		.GO(gOut),
		.PO(pOut),
		.CO(cOut)
	);

	// carry back in also when every bit propagates, so all-ones folds to zero
	assign cIn = cOut | pOut[width-1];

	assign S = halfSum ^ {gOut[width-2:0], cIn};  // carry into bit i from bit i-1

endmodule

// one more prefix level merging a carry into every generate bit
module PrefixAndOrCendaround #(
	parameter int width = 16,
	parameter int speed = 0
) (
	input  logic [width-1:0] GI,
	input  logic [width-1:0] PI,
	input  logic             CI,  // carry in, end-around
	output logic [width-1:0] GO,
	output logic [width-1:0] PO,
	output logic             CO   // carry out of msb
);

	logic [width-1:0] gGrp, pGrp;  // group signals bit 0..i

	PrefixAndOr #(
		.width(width),
		.speed(speed)
	) i_tree (
		.GI(GI),
		.PI(PI),
		.GO(gGrp),
		.PO(pGrp)
	);

	assign CO = gGrp[width-1];
	assign GO = gGrp | (pGrp & {width{CI}});  // carry ripples through propagating groups
	assign PO = pGrp;

endmodule

// generate / propagate prefix, structure picked by speed
module PrefixAndOr #(
	parameter int width = 16,
	parameter int speed = 0
) (
	input  logic [width-1:0] GI,
	input  logic [width-1:0] PI,
	output logic [width-1:0] GO,  // group generate, bits 0..i
	output logic [width-1:0] PO   // group propagate, bits 0..i
);

	localparam int n = width;
	localparam int m = $clog2(width);  // tree depth

	if (speed == int'(CsumPkg::sklansky)) begin : fastPrefix
		logic [n-1:0] gT [0:m];  // one row per level
		logic [n-1:0] pT [0:m];
		assign gT[0] = GI;
		assign pT[0] = PI;
		for (genvar l = 1; l <= m; l++) begin : levels
			for (genvar i = 0; i < n; i++) begin : bits
				// upper half of each 2^l block takes the lower half's top bit
				if ((i % 2**l) >= 2**(l-1)) begin : black
					localparam int j = (i / 2**l) * 2**l + 2**(l-1) - 1;
					assign gT[l][i] = gT[l-1][i] | (pT[l-1][i] & gT[l-1][j]);
					assign pT[l][i] = pT[l-1][i] & pT[l-1][j];
				end else begin : white
					assign gT[l][i] = gT[l-1][i];
					assign pT[l][i] = pT[l-1][i];
				end
			end
		end
		assign GO = gT[m];
		assign PO = pT[m];
	end else if (speed == int'(CsumPkg::brentKung)) begin : mediumPrefix
		logic [n-1:0] gT [0:2*m-1];
		logic [n-1:0] pT [0:2*m-1];
		assign gT[0] = GI;
		assign pT[0] = PI;
		for (genvar l = 1; l <= m; l++) begin : levels1  // up sweep
			for (genvar i = 0; i < n; i++) begin : bits
				if (((i + 1) % 2**l) == 0) begin : black
					assign gT[l][i] = gT[l-1][i] | (pT[l-1][i] & gT[l-1][i-2**(l-1)]);
					assign pT[l][i] = pT[l-1][i] & pT[l-1][i-2**(l-1)];
				end else begin : white
					assign gT[l][i] = gT[l-1][i];
					assign pT[l][i] = pT[l-1][i];
				end
			end
		end
		for (genvar l = m + 1; l < 2*m; l++) begin : levels2  // down sweep
			localparam int d = 2*m - l;  // block size 2^d at this level
			for (genvar i = 0; i < n; i++) begin : bits
				if (i >= 2**d && ((i + 1) % 2**d) == 2**(d-1)) begin : black
					assign gT[l][i] = gT[l-1][i] | (pT[l-1][i] & gT[l-1][i-2**(d-1)]);
					assign pT[l][i] = pT[l-1][i] & pT[l-1][i-2**(d-1)];
				end else begin : white
					assign gT[l][i] = gT[l-1][i];
					assign pT[l][i] = pT[l-1][i];
				end
			end
		end
		assign GO = gT[2*m-1];
		assign PO = pT[2*m-1];
	end else begin : slowPrefix
		logic [n-1:0] gT, pT;
		assign gT[0] = GI[0];
		assign pT[0] = PI[0];
		for (genvar i = 1; i < n; i++) begin : bits
			assign gT[i] = GI[i] | (PI[i] & gT[i-1]);  // ripple chain
			assign pT[i] = PI[i] & pT[i-1];
		end
		assign GO = gT;
		assign PO = pT;
	end

endmodule

/* src/ChecksumEngine.sv */
`timescale 1ns/100ps

// reads len words from base over wishbone, sums them mod 2^16-1
module ChecksumEngine #(
	parameter CsumPkg::speed_e speed = CsumPkg::serial  // adder prefix structure
) (
	input  logic              clk,
	input  logic              arstN,
	input  logic              start,  // ignored while busy
	input  WbPkg::adr_t       base,   // first word
	input  CsumPkg::len_t     len,    // word count, 0 allowed
	output logic              busy,
	output logic              done,   // single pulse, sum valid from here
	output CsumPkg::residue_t sum,
	WbBus.master              bus
);

	typedef enum logic [1:0] {sIdle, sReq, sWait} state_e;

	state_e            state;
	WbPkg::adr_t       adrQ;      // address of current word
	CsumPkg::len_t     remQ;      // words still to fetch, incl. current
	CsumPkg::residue_t accQ;
	CsumPkg::residue_t accNext;   // accQ + datR mod 2^16-1
	logic              doneQ;
	logic              lastWord;

	AddMod2Nm1s0 #(
		.width($bits(CsumPkg::residue_t)),
		.speed(int'(speed))
	) i_add (
		.A(accQ),
		.B(bus.datR),  // only taken in the ack cycle
		.S(accNext)
	);

	assign lastWord = (remQ == CsumPkg::len_t'(1));

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			state <= sIdle;
			accQ  <= '0;
			doneQ <= 1'b0;
		end else begin
			doneQ <= 1'b0;
			case (state)
				sIdle: if (start) begin
					accQ <= '0;
					if (len == '0) doneQ <= 1'b1;  // empty run, done right away
					else state <= sReq;
				end
				sReq: state <= sWait;  // first cycle of a transfer, ack still low
				sWait: if (bus.ack) begin
					accQ <= accNext;
					if (lastWord) begin
						doneQ <= 1'b1;
						state <= sIdle;  // drops cyc, frees the arbiter
					end else begin
						state <= sReq;   // next address, cyc stays up
					end
				end
				default: state <= sIdle;
			endcase
		end
	end

	// address and count, loaded on start
	always_ff @(posedge clk) begin
		if (state == sIdle && start) begin
			adrQ <= base;
			remQ <= len;
		end else if (state == sWait && bus.ack) begin
			adrQ <= adrQ + WbPkg::adr_t'(1);
			remQ <= remQ - CsumPkg::len_t'(1);
		end
	end

	assign busy = (state != sIdle);
	assign done = doneQ;
	assign sum  = accQ;

	assign bus.cyc  = busy;  // bus held for the whole run
	assign bus.stb  = busy;
	assign bus.we   = 1'b0;  // read only
	assign bus.adr  = adrQ;
	assign bus.datW = '0;

endmodule

/* src/WbArbiter.sv */
`timescale 1ns/100ps
`include "csumParams.svh"

// round robin, owner keeps the bus as long as its cyc is high
module WbArbiter (
	input logic  clk,
	input logic  arstN,
	WbBus.slave  mst [`WB_MASTERS],
	WbBus.master slv
);

	localparam int N = `WB_MASTERS;

	logic [N-1:0] reqCyc, reqStb, reqWe;
	WbPkg::adr_t  reqAdr [N];
	WbPkg::dat_t  reqDatW [N];
	WbPkg::mst_t  owner;     // current owner, also last granted
	WbPkg::mst_t  pick;      // next requester after owner
	logic         ownValid;
	logic         found;
	logic         free;      // nobody holds the bus this cycle

	for (genvar g = 0; g < N; g++) begin : ports
		assign reqCyc[g]  = mst[g].cyc;
		assign reqStb[g]  = mst[g].stb;
		assign reqWe[g]   = mst[g].we;
		assign reqAdr[g]  = mst[g].adr;
		assign reqDatW[g] = mst[g].datW;
		assign mst[g].datR = slv.datR;  // broadcast, only ack qualifies it
		assign mst[g].ack  = slv.ack & ownValid & (owner == WbPkg::mst_t'(g));
	end

	assign free = !ownValid || !reqCyc[owner];

	always_comb begin : rrPick
		int idx;
		pick  = owner;
		found = 1'b0;
		for (int off = 1; off <= N; off++) begin  // off == N is the old owner again
			idx = (int'(owner) + off) % N;
			if (!found && reqCyc[idx]) begin
				found = 1'b1;
				pick  = WbPkg::mst_t'(idx);
			end
		end
	end

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			owner    <= WbPkg::mst_t'(N - 1);  // host comes first after reset
			ownValid <= 1'b0;
		end else if (free) begin
			ownValid <= found;
			if (found) owner <= pick;
		end
	end

	assign slv.cyc  = ownValid & reqCyc[owner];
	assign slv.stb  = ownValid & reqCyc[owner] & reqStb[owner];
	assign slv.we   = reqWe[owner];
	assign slv.adr  = reqAdr[owner];
	assign slv.datW = reqDatW[owner];

endmodule

/* src/PacketBuffer.sv */
`timescale 1ns/100ps
`include "csumParams.svh"

// single port word memory behind a wishbone slave
module PacketBuffer (
	input logic clk,
	input logic arstN,
	WbBus.slave bus
);

	WbPkg::dat_t mem [0:`BUF_DEPTH-1];
	WbPkg::dat_t datRQ;  // read word, shown in ack cycle
	logic        ackQ;
	logic        take;   // new request seen

	// ack low gap after each transfer keeps a held stb from double acking
	assign take = bus.cyc & bus.stb & ~ackQ;

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			ackQ <= 1'b0;
		end else begin
			ackQ <= take;  // one cycle pulse
		end
	end

	always_ff @(posedge clk) begin
		if (take) begin
			if (bus.we) begin
				mem[bus.adr] <= bus.datW;
			end else begin
				datRQ <= mem[bus.adr];
			end
		end
	end

	assign bus.ack  = ackQ;
	assign bus.datR = datRQ;  // stale outside ack, masters ignore it

endmodule

/* src/ChecksumTop.sv */
`timescale 1ns/100ps
`include "csumParams.svh"

// host port plus two checksum engines sharing one packet buffer
module ChecksumTop (
	input  logic              clk,
	input  logic              arstN,
	input  logic              hostCyc,
	input  logic              hostStb,
	input  logic              hostWe,
	input  WbPkg::adr_t       hostAdr,
	input  WbPkg::dat_t       hostDatW,
	output WbPkg::dat_t       hostDatR,
	output logic              hostAck,
	input  logic              startA,
	input  WbPkg::adr_t       baseA,
	input  CsumPkg::len_t     lenA,
	output logic              busyA,
	output logic              doneA,
	output CsumPkg::residue_t sumA,
	input  logic              startB,
	input  WbPkg::adr_t       baseB,
	input  CsumPkg::len_t     lenB,
	output logic              busyB,
	output logic              doneB,
	output CsumPkg::residue_t sumB
);

	WbBus mstBus [`WB_MASTERS] ();  // indexed by WbPkg master ids
	WbBus slvBus ();

	// host pins onto master 0
	assign mstBus[WbPkg::mstHost].cyc  = hostCyc;
	assign mstBus[WbPkg::mstHost].stb  = hostStb;
	assign mstBus[WbPkg::mstHost].we   = hostWe;
	assign mstBus[WbPkg::mstHost].adr  = hostAdr;
	assign mstBus[WbPkg::mstHost].datW = hostDatW;
	assign hostDatR = mstBus[WbPkg::mstHost].datR;
	assign hostAck  = mstBus[WbPkg::mstHost].ack;

	ChecksumEngine #(.speed(CsumPkg::serial)) i_engA (
		.clk(clk), .arstN(arstN),
		.start(startA), .base(baseA), .len(lenA),
		.busy(busyA), .done(doneA), .sum(sumA),
		.bus(mstBus[WbPkg::mstA])
	);

	ChecksumEngine #(.speed(CsumPkg::sklansky)) i_engB (
		.clk(clk), .arstN(arstN),
		.start(startB), .base(baseB), .len(lenB),
		.busy(busyB), .done(doneB), .sum(sumB),
		.bus(mstBus[WbPkg::mstB])
	);

	WbArbiter i_arb (.clk(clk), .arstN(arstN), .mst(mstBus), .slv(slvBus));

	PacketBuffer i_buf (.clk(clk), .arstN(arstN), .bus(slvBus));

endmodule

/* test/tbChecksumTop.sv */
`timescale 1ns/100ps
`include "csumParams.svh"

// directed tests for the checksum subsystem, host port plus both engines
module tbChecksumTop;

	localparam int hostWords   = 8 + 8 + 10 + 1 + 32;       // host transfers, all tests
	localparam int engineWords = 14 + 12 + 18 + 64 + 12;    // words fetched by engines
	localparam int totalWords  = hostWords + engineWords;
	localparam int limitCycles = totalWords * 20 + 500;

	logic clk, arstN;
	logic hostCyc, hostStb, hostWe;
	WbPkg::adr_t hostAdr;
	WbPkg::dat_t hostDatW, hostDatR;
	logic hostAck;
	logic startA, startB, busyA, busyB, doneA, doneB;
	WbPkg::adr_t baseA, baseB;
	CsumPkg::len_t lenA, lenB;
	CsumPkg::residue_t sumA, sumB;

	CsumPkg::word_t shadow [`BUF_DEPTH];  // what the buffer should hold
	logic [15:0] lfsrState = 16'd86;
	int testErr = 0;
	int errCount = 0;
	int testsRun = 0;
	int testsFailed = 0;

	ChecksumTop i_dut (
		.clk(clk), .arstN(arstN),
		.hostCyc(hostCyc), .hostStb(hostStb), .hostWe(hostWe), .hostAdr(hostAdr),
		.hostDatW(hostDatW), .hostDatR(hostDatR), .hostAck(hostAck),
		.startA(startA), .baseA(baseA), .lenA(lenA),
		.busyA(busyA), .doneA(doneA), .sumA(sumA),
		.startB(startB), .baseB(baseB), .lenB(lenB),
		.busyB(busyB), .doneB(doneB), .sumB(sumB)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;  // 8 ns period
	end

	initial begin
		#(limitCycles * 8);
		$display("watchdog: run did not finish within %0d cycles", limitCycles);
		$display("TB FAILED");
		$finish;
	end

	function automatic logic [15:0] galoisStep(input logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);  // taps 16,14,13,11
	endfunction

	// one lfsr step per bit taken
	task automatic randWord(output CsumPkg::word_t w);
		w = '0;
		for (int i = 0; i < 16; i++) begin
			w = {w[14:0], lfsrState[0]};
			lfsrState = galoisStep(lfsrState);
		end
	endtask

	// residue rule: plain sum mod 65535, so 65535 lands on 0
	function automatic CsumPkg::residue_t refSum(input int base, input int len);
		int acc;
		acc = 0;
		for (int i = 0; i < len; i++)
			acc = (acc + int'(shadow[base + i])) % 65535;
		return CsumPkg::residue_t'(acc);
	endfunction

	task automatic checkWord(input string name, input CsumPkg::word_t exp,
			input CsumPkg::word_t act);
		if (act !== exp) begin
			$display("error %s: expected %h, actual %h", name, exp, act);
			testErr++;
		end
	endtask

	task automatic checkResidue(input string name, input CsumPkg::residue_t exp,
			input CsumPkg::residue_t act);
		if (act !== exp) begin
			$display("error %s: expected %h, actual %h", name, exp, act);
			testErr++;
		end
	endtask

	task automatic finishTest(input string name);
		testsRun++;
		if (testErr == 0) $display("%s: ok", name);
		else begin
			testsFailed++;
			$display("%s: %0d mismatches", name, testErr);
		end
		errCount += testErr;
		testErr = 0;
	endtask

	task automatic hostWrite(input int adr, input CsumPkg::word_t data);
		@(posedge clk);
		hostCyc <= 1'b1;
		hostStb <= 1'b1;
		hostWe <= 1'b1;
		hostAdr <= WbPkg::adr_t'(adr);
		hostDatW <= data;
		do @(posedge clk); while (hostAck !== 1'b1);
		hostCyc <= 1'b0;  // drop in the cycle after ack
		hostStb <= 1'b0;
		shadow[adr] = data;
	endtask

	task automatic hostRead(input int adr, output CsumPkg::word_t data);
		@(posedge clk);
		hostCyc <= 1'b1;
		hostStb <= 1'b1;
		hostWe <= 1'b0;
		hostAdr <= WbPkg::adr_t'(adr);
		do @(posedge clk); while (hostAck !== 1'b1);
		data = hostDatR;  // valid in the ack cycle
		hostCyc <= 1'b0;
		hostStb <= 1'b0;
	endtask

	task automatic startEngine(input bit engB, input int base, input int len);
		@(posedge clk);
		if (engB) begin
			startB <= 1'b1;
			baseB <= WbPkg::adr_t'(base);
			lenB <= CsumPkg::len_t'(len);
		end else begin
			startA <= 1'b1;
			baseA <= WbPkg::adr_t'(base);
			lenA <= CsumPkg::len_t'(len);
		end
		@(posedge clk);
		if (engB) startB <= 1'b0;  // one cycle pulse
		else startA <= 1'b0;
	endtask

	task automatic waitDone(input bit engB, output CsumPkg::residue_t sum);
		do @(posedge clk); while ((engB ? doneB : doneA) !== 1'b1);
		sum = engB ? sumB : sumA;  // sum valid with done
		if ((engB ? busyB : busyA) !== 1'b0) begin
			$display("engine %s still busy in its done cycle", engB ? "B" : "A");
			testErr++;
		end
	endtask

	task automatic runEngine(input bit engB, input int base, input int len,
			output CsumPkg::residue_t sum);
		startEngine(engB, base, len);
		if (len > 0) begin
			@(posedge clk);  // first cycle of the run, done cannot come yet
			if ((engB ? busyB : busyA) !== 1'b1) begin
				$display("engine %s not busy after its start", engB ? "B" : "A");
				testErr++;
			end
		end
		waitDone(engB, sum);
	endtask

	task automatic testBufferAccess();
		CsumPkg::word_t d;
		for (int a = 0; a < 8; a++)
			hostWrite(a, {2'b10, 6'(a), 2'b01, ~6'(a)});  // pattern carries the address
		for (int a = 7; a >= 0; a--) begin
			hostRead(a, d);
			checkWord("bufferAccess", shadow[a], d);
		end
		finishTest("bufferAccess");
	endtask

	task automatic testSerialEngine();
		CsumPkg::word_t dir [10] = '{16'hFFFF, 16'hFFFF, 16'h8000, 16'h9000, 16'h1234,
			16'hEDCB, 16'h0001, 16'hFFFE, 16'h7FFF, 16'h0000};
		CsumPkg::residue_t s;
		for (int i = 0; i < 10; i++)
			hostWrite(16 + i, dir[i]);  // directed region at 16
		runEngine(1'b0, 16, 10, s);
		checkResidue("serialEngine", refSum(16, 10), s);
		runEngine(1'b0, 20, 2, s);  // 0x1234 + 0xEDCB is exactly 65535
		checkResidue("serialEngine", 16'h0000, s);
		runEngine(1'b0, 16, 2, s);
		checkResidue("serialEngine", refSum(16, 2), s);
		finishTest("serialEngine");
	endtask

	task automatic testSklanskyEngine();
		CsumPkg::residue_t s;
		runEngine(1'b1, 16, 10, s);
		checkResidue("sklanskyEngine", refSum(16, 10), s);
		runEngine(1'b1, 22, 2, s);  // 0x0001 + 0xFFFE
		checkResidue("sklanskyEngine", 16'h0000, s);
		finishTest("sklanskyEngine");
	endtask

	task automatic testContention();
		CsumPkg::residue_t sA, sB;
		CsumPkg::word_t d;
		fork
			runEngine(1'b0, 16, 10, sA);
			runEngine(1'b1, 0, 8, sB);
			begin
				@(posedge clk);  // host cyc lines up with both engines' cyc
				hostRead(20, d);  // all three request in the same cycle
			end
		join
		checkResidue("contention", refSum(16, 10), sA);
		checkResidue("contention", refSum(0, 8), sB);
		checkWord("contention", shadow[20], d);
		finishTest("contention");
	endtask

	task automatic testRandomData();
		CsumPkg::word_t w;
		CsumPkg::residue_t s;
		for (int i = 0; i < 32; i++) begin
			randWord(w);
			hostWrite(32 + i, w);
		end
		runEngine(1'b0, 32, 32, s);
		checkResidue("randomData", refSum(32, 32), s);
		runEngine(1'b1, 32, 32, s);
		checkResidue("randomData", refSum(32, 32), s);
		finishTest("randomData");
	endtask

	task automatic testEmptyRun();
		CsumPkg::residue_t s;
		runEngine(1'b0, 5, 0, s);  // previous sums were nonzero
		checkResidue("emptyRun", 16'h0000, s);
		runEngine(1'b1, 40, 0, s);
		checkResidue("emptyRun", 16'h0000, s);
		finishTest("emptyRun");
	endtask

	task automatic testStartWhileBusy();
		CsumPkg::residue_t s;
		startEngine(1'b0, 32, 12);
		do @(posedge clk); while (busyA !== 1'b1);
		startA <= 1'b1;  // second start with other region, must be ignored
		baseA <= WbPkg::adr_t'(0);
		lenA <= CsumPkg::len_t'(3);
		@(posedge clk);
		startA <= 1'b0;
		waitDone(1'b0, s);
		checkResidue("startWhileBusy", refSum(32, 12), s);
		@(posedge clk);
		if (busyA !== 1'b0) begin
			$display("startWhileBusy: engine A still busy after its done pulse");
			testErr++;
		end
		finishTest("startWhileBusy");
	endtask

	initial begin
		hostCyc = 1'b0;
		hostStb = 1'b0;
		hostWe = 1'b0;
		hostAdr = '0;
		hostDatW = '0;
		startA = 1'b0;
		baseA = '0;
		lenA = '0;
		startB = 1'b0;
		baseB = '0;
		lenB = '0;
		arstN = 1'b0;
		repeat (3) @(posedge clk);
		arstN <= 1'b1;
		testBufferAccess();
		testSerialEngine();
		testSklanskyEngine();
		testContention();
		testRandomData();
		testEmptyRun();
		testStartWhileBusy();
		$display("tests run %0d, tests failed %0d, mismatches %0d",
			testsRun, testsFailed, errCount);
		if (errCount == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

endmodule

/* sim.f */
+incdir+include
src/CsumPkg.sv
src/WbPkg.sv
src/WbBus.sv
src/AddMod2Nm1s0.sv
src/ChecksumEngine.sv
src/WbArbiter.sv
src/PacketBuffer.sv
src/ChecksumTop.sv
test/tbChecksumTop.sv
